//--- sublane_pkg.sv
`default_nettype none

package sublane_pkg;

   // instruction kinds the sequencer handles
   typedef enum logic [1:0] {
      INST_NORMAL = 2'd0,   // read, write back after the delay
      INST_STORE  = 2'd1,   // read only
      INST_LOAD   = 2'd2    // writes follow the load beats
   } inst_kind_t;

   typedef enum logic [1:0] {
      EW_BYTE = 2'd0,
      EW_HALF = 2'd1,
      EW_WORD = 2'd2
   } elem_width_t;

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_NORMAL = 2'd1,
      ST_STORE  = 2'd2,
      ST_LOAD   = 2'd3
   } seq_state_t;

   localparam int BYTES_PER_WORD = 4;
   localparam int BYTE_SEL_W     = $clog2(BYTES_PER_WORD);   // slot index inside a word

   // index of the last element slot in one VRF word
   function automatic logic [BYTE_SEL_W-1:0] last_slot(elem_width_t w);
      logic [BYTE_SEL_W-1:0] slot;
      case (w)
         EW_BYTE: slot = BYTE_SEL_W'(BYTES_PER_WORD - 1);
         EW_HALF: slot = BYTE_SEL_W'(BYTES_PER_WORD / 2 - 1);
         default: slot = '0;   // one word per element
      endcase
      return slot;
   endfunction

endpackage

`default_nettype wire

//--- sublane_cfg_regs.sv
`default_nettype none

module sublane_cfg_regs #(
   parameter int VLANE_NUM       = 8,
   parameter int MAX_VL_PER_LANE = 256,
   localparam int VL_W  = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1),
   localparam int DLY_W = $clog2(MAX_VL_PER_LANE),
   localparam int EPL_W = $clog2(MAX_VL_PER_LANE + 1)
) (
   input  wire logic                     clk_i,
   input  wire logic                     rstn_i,
   input  wire logic                     accept_i,
   input  wire sublane_pkg::inst_kind_t  inst_kind_i,
   input  wire logic [VL_W-1:0]          vl_i,
   input  wire sublane_pkg::elem_width_t vsew_i,
   input  wire logic [DLY_W-1:0]         inst_delay_i,
   output sublane_pkg::inst_kind_t       kind_o,
   output sublane_pkg::elem_width_t      rd_width_o,
   output sublane_pkg::elem_width_t      wr_width_o,
   output logic [DLY_W-1:0]              delay_o,
   output logic [EPL_W-1:0]              elems_per_lane_o,
   output logic [VL_W-1:0]               vl_o
);

   import sublane_pkg::*;

   logic [VL_W:0]    vl_round;   // vl plus lanes minus one
   logic [EPL_W-1:0] epl_calc;

   // elements per lane rounded up
   assign vl_round = {1'b0, vl_i} + (VL_W + 1)'(VLANE_NUM - 1);
   assign epl_calc = EPL_W'(vl_round / VLANE_NUM);

   ////////////////////
   // control settings
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         kind_o     <= INST_NORMAL;
         rd_width_o <= EW_WORD;
         wr_width_o <= EW_WORD;
      end else if (accept_i) begin
         kind_o     <= inst_kind_i;
         rd_width_o <= (inst_kind_i == INST_STORE) ? EW_WORD : vsew_i;   // stores read whole words
         wr_width_o <= (inst_kind_i == INST_LOAD) ? EW_WORD : vsew_i;    // load beats are words
      end
   end

   // instruction lengths
   always_ff @(posedge clk_i) begin
      if (accept_i) begin
         delay_o          <= inst_delay_i;
         elems_per_lane_o <= epl_calc;
         vl_o             <= vl_i;
      end
   end

endmodule

`default_nettype wire

//--- sublane_fsm.sv
`default_nettype none

module sublane_fsm #(
   parameter int VLANE_NUM       = 8,
   parameter int MAX_VL_PER_LANE = 256,
   localparam int VL_W  = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1),
   localparam int DLY_W = $clog2(MAX_VL_PER_LANE),
   localparam int EPL_W = $clog2(MAX_VL_PER_LANE + 1),
   localparam int CNT_W = $clog2(2 * MAX_VL_PER_LANE) + 1,
   localparam int IDX_W = CNT_W + $clog2(VLANE_NUM) + 1
) (
   input  wire logic                    clk_i,
   input  wire logic                    rstn_i,
   input  wire logic                    start_i,
   input  wire sublane_pkg::inst_kind_t kind_i,
   input  wire logic [DLY_W-1:0]        delay_i,
   input  wire logic [EPL_W-1:0]        elems_per_lane_i,
   input  wire logic [VL_W-1:0]         vl_i,
   input  wire logic                    load_valid_i,
   input  wire logic                    load_last_i,
   output logic                         accept_o,
   output logic                         addr_load_o,
   output logic                         rd_step_o,
   output logic                         wr_step_o,
   output sublane_pkg::seq_state_t      state_o,
   output logic                         ready_o,
   output logic [VLANE_NUM-1:0]         read_data_valid_o,
   output logic                         store_data_valid_o,
   output logic                         ready_for_load_o
);

   import sublane_pkg::*;

   seq_state_t       state_q, state_d;
   logic             pending_q;          // settings latched, kind known next edge
   logic [CNT_W-1:0] cnt_q;              // element being read in this cycle
   logic [CNT_W-1:0] cnt_nxt;
   logic [CNT_W-1:0] rd_len, wr_end;
   logic [CNT_W-1:0] elem_nxt;           // element shown after the next edge
   logic             rd_phase, rd_next, done;
   logic [IDX_W-1:0] lane_pos [VLANE_NUM];

   assign accept_o    = start_i & ready_o;
   assign addr_load_o = accept_o;
   assign state_o     = state_q;
   assign ready_for_load_o = (state_q == ST_LOAD);

   assign cnt_nxt = cnt_q + 1'b1;
   assign rd_len  = CNT_W'(elems_per_lane_i);
   assign wr_end  = CNT_W'(delay_i) + CNT_W'(elems_per_lane_i);

   ////////////////////
   // read and write phases
   assign rd_phase  = (state_q == ST_NORMAL) || (state_q == ST_STORE);
   assign rd_step_o = rd_phase && (cnt_nxt < rd_len);   // more reads follow
   assign rd_next   = (pending_q && (kind_i != INST_LOAD) && (rd_len != '0)) || rd_step_o;
   assign elem_nxt  = pending_q ? '0 : cnt_nxt;

   always_comb begin
      case (state_q)
         ST_NORMAL: wr_step_o = (cnt_q >= CNT_W'(delay_i)) && (cnt_q < wr_end);
         ST_LOAD:   wr_step_o = load_valid_i;   // one word per beat
         default:   wr_step_o = 1'b0;
      endcase
   end

   always_comb begin
      state_d = state_q;
      done    = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (pending_q) begin
               case (kind_i)
                  INST_STORE: state_d = ST_STORE;
                  INST_LOAD:  state_d = ST_LOAD;
                  default:    state_d = ST_NORMAL;
               endcase
            end
         end
         ST_NORMAL: done = (cnt_nxt >= wr_end);    // last write on show
         ST_STORE:  done = (cnt_nxt >= rd_len);
         ST_LOAD:   done = load_valid_i & load_last_i;
         default:   done = 1'b1;
      endcase
      if (done) begin
         state_d = ST_IDLE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_q   <= ST_IDLE;
         pending_q <= 1'b0;
         cnt_q     <= '0;
         ready_o   <= 1'b1;
      end else begin
         state_q   <= state_d;
         pending_q <= accept_o;
         cnt_q     <= (rd_phase && !done) ? cnt_nxt : '0;
         if (accept_o) begin
            ready_o <= 1'b0;
         end else if (done) begin
            ready_o <= 1'b1;
         end
      end
   end

   ////////////////////
   // per-lane valid
   always_comb begin
      for (int i = 0; i < VLANE_NUM; i++) begin
         lane_pos[i] = IDX_W'(elem_nxt) * IDX_W'(VLANE_NUM) + IDX_W'(i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         read_data_valid_o  <= '0;
         store_data_valid_o <= 1'b0;
      end else begin
         for (int i = 0; i < VLANE_NUM; i++) begin
            read_data_valid_o[i] <= rd_next && (lane_pos[i] < IDX_W'(vl_i));   // tail lanes drop out
         end
         store_data_valid_o <= rd_next && (kind_i == INST_STORE);
      end
   end

endmodule

`default_nettype wire

//--- vrf_addr_counter.sv
`default_nettype none

module vrf_addr_counter #(
   parameter int MEM_DEPTH = 512,
   localparam int AW = $clog2(MEM_DEPTH)
) (
   input  wire logic                     clk_i,
   input  wire logic                     rstn_i,
   input  wire logic                     load_i,
   input  wire logic [AW-1:0]            base_i,
   input  wire sublane_pkg::elem_width_t width_i,
   input  wire logic                     step_i,
   output logic [AW-1:0]                 addr_o
);

   import sublane_pkg::*;

   logic [BYTE_SEL_W-1:0] slot_q;   // elements already passed in this word
   logic                  word_done;

   // group complete once the last slot of the word steps
   assign word_done = (slot_q == last_slot(width_i));

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         addr_o <= '0;
         slot_q <= '0;
      end else if (load_i) begin
         addr_o <= base_i;
         slot_q <= '0;
      end else if (step_i) begin
         if (word_done) begin
            addr_o <= addr_o + 1'b1;   // wraps at the end of the VRF
            slot_q <= '0;
         end else begin
            slot_q <= slot_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- byte_enable_gen.sv
`default_nettype none

module byte_enable_gen (
   input  wire logic                                  clk_i,
   input  wire logic                                  rstn_i,
   input  wire logic                                  restart_i,
   input  wire sublane_pkg::elem_width_t              width_i,
   input  wire logic                                  step_i,
   output logic [sublane_pkg::BYTES_PER_WORD-1:0]     bwen_o,
   output logic                                       wrap_o
);

   import sublane_pkg::*;

   localparam int HALF_B = BYTES_PER_WORD / 2;

   logic [BYTES_PER_WORD-1:0] onehot_q;    // byte slot of the current element
   logic                      half_hi_q;   // upper halfword selected
   logic [BYTES_PER_WORD-1:0] pattern;
   logic                      last;

   always_comb begin
      case (width_i)
         EW_BYTE: begin
            pattern = onehot_q;
            last    = onehot_q[BYTES_PER_WORD-1];
         end
         EW_HALF: begin
            pattern = {{HALF_B{half_hi_q}}, {HALF_B{~half_hi_q}}};
            last    = half_hi_q;
         end
         EW_WORD: begin
            pattern = '1;
            last    = 1'b1;
         end
         default: begin
            pattern = '0;
            last    = 1'b1;
         end
      endcase
   end

   assign bwen_o = step_i ? pattern : '0;   // quiet between writes
   assign wrap_o = step_i & last;

   always_ff @(posedge clk_i) begin
      if (!rstn_i || restart_i) begin
         onehot_q  <= BYTES_PER_WORD'(1);
         half_hi_q <= 1'b0;
      end else if (step_i) begin
         onehot_q  <= {onehot_q[BYTES_PER_WORD-2:0], onehot_q[BYTES_PER_WORD-1]};
         half_hi_q <= ~half_hi_q;
      end
   end

endmodule

`default_nettype wire

//--- sublane_driver.sv
`default_nettype none

module sublane_driver #(
   parameter int VLANE_NUM       = 8,
   parameter int MEM_DEPTH       = 512,
   parameter int MAX_VL_PER_LANE = 256,
   localparam int AW       = $clog2(MEM_DEPTH),
   localparam int VL_W     = $clog2(VLANE_NUM * MAX_VL_PER_LANE + 1),
   localparam int DLY_W    = $clog2(MAX_VL_PER_LANE),
   localparam int EPL_W    = $clog2(MAX_VL_PER_LANE + 1),
   localparam int BPW      = sublane_pkg::BYTES_PER_WORD,
   localparam int RD_PORTS = 2
) (
   input  wire logic                       clk_i,
   input  wire logic                       rstn_i,
   input  wire logic                       start_i,
   input  wire sublane_pkg::inst_kind_t    inst_kind_i,
   input  wire logic [VL_W-1:0]            vl_i,
   input  wire sublane_pkg::elem_width_t   vsew_i,
   input  wire logic [DLY_W-1:0]           inst_delay_i,
   input  wire logic [AW-1:0]              waddr_base_i,
   input  wire logic [RD_PORTS-1:0][AW-1:0] raddr_base_i,   // vs1, vs2
   input  wire logic                       load_valid_i,
   input  wire logic                       load_last_i,
   input  wire logic [VLANE_NUM-1:0][BPW-1:0] load_bwen_i,
   output logic                            ready_o,
   output logic [AW-1:0]                   vrf_waddr_o,
   output logic [RD_PORTS-1:0][AW-1:0]     vrf_raddr_o,
   output logic [VLANE_NUM-1:0][BPW-1:0]   vrf_bwen_o,
   output logic [VLANE_NUM-1:0]            read_data_valid_o,
   output logic                            store_data_valid_o,
   output logic                            ready_for_load_o
);

   import sublane_pkg::*;

   inst_kind_t       kind;
   elem_width_t      rd_width, wr_width;
   logic [DLY_W-1:0] delay;
   logic [EPL_W-1:0] elems_per_lane;
   logic [VL_W-1:0]  vl_q;
   logic             accept, addr_load, rd_step, wr_step;
   seq_state_t       state;
   logic [BPW-1:0]   gen_bwen;   // same pattern for every lane
   logic             wr_wrap;

   sublane_cfg_regs #(.VLANE_NUM(VLANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) u_cfg (
      .clk_i(clk_i), .rstn_i(rstn_i), .accept_i(accept),
      .inst_kind_i(inst_kind_i), .vl_i(vl_i), .vsew_i(vsew_i), .inst_delay_i(inst_delay_i),
      .kind_o(kind), .rd_width_o(rd_width), .wr_width_o(wr_width),
      .delay_o(delay), .elems_per_lane_o(elems_per_lane), .vl_o(vl_q)
   );

   sublane_fsm #(.VLANE_NUM(VLANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) u_fsm (
      .clk_i(clk_i), .rstn_i(rstn_i), .start_i(start_i),
      .kind_i(kind), .delay_i(delay), .elems_per_lane_i(elems_per_lane), .vl_i(vl_q),
      .load_valid_i(load_valid_i), .load_last_i(load_last_i),
      .accept_o(accept), .addr_load_o(addr_load), .rd_step_o(rd_step), .wr_step_o(wr_step),
      .state_o(state), .ready_o(ready_o), .read_data_valid_o(read_data_valid_o),
      .store_data_valid_o(store_data_valid_o), .ready_for_load_o(ready_for_load_o)
   );

   ////////////////////
   // address counters
   vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) u_waddr_cnt (
      .clk_i(clk_i), .rstn_i(rstn_i), .load_i(addr_load), .base_i(waddr_base_i),
      .width_i(EW_WORD),   // steps on every wrap from the generator
      .step_i(wr_wrap), .addr_o(vrf_waddr_o)
   );

   for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd_cnt
      vrf_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) u_raddr_cnt (
         .clk_i(clk_i), .rstn_i(rstn_i), .load_i(addr_load), .base_i(raddr_base_i[p]),
         .width_i(rd_width), .step_i(rd_step), .addr_o(vrf_raddr_o[p])
      );
   end

   byte_enable_gen u_bwen_gen (
      .clk_i(clk_i), .rstn_i(rstn_i), .restart_i(addr_load),
      .width_i(wr_width), .step_i(wr_step), .bwen_o(gen_bwen), .wrap_o(wr_wrap)
   );

   // load beats bring their own byte enables
   always_comb begin
      for (int i = 0; i < VLANE_NUM; i++) begin
         vrf_bwen_o[i] = (state == ST_LOAD) ? load_bwen_i[i] : gen_bwen;
      end
   end

endmodule

`default_nettype wire

//--- sublane_assertions.sv
`default_nettype none

module sublane_assertions #(
   parameter int VLANE_NUM = 8
) (
   input wire logic                                            clk_i,
   input wire logic                                            rstn_i,
   input wire sublane_pkg::seq_state_t                         state_i,
   input wire logic [VLANE_NUM*sublane_pkg::BYTES_PER_WORD-1:0] bwen_i,
   input wire logic                                            store_valid_i,
   input wire logic                                            ready_i,
   input wire logic                                            ready_for_load_i
);
   timeunit 1ns;
   timeprecision 1ps;

   import sublane_pkg::*;

   // stores only read, so every lane stays quiet
   a_no_write_on_store : assert property (@(posedge clk_i) disable iff (!rstn_i)
      store_valid_i |-> (bwen_i == '0)) else $error("byte enable active during a store read");

   a_ready_exclusive : assert property (@(posedge clk_i) disable iff (!rstn_i)
      !(ready_for_load_i && ready_i)) else $error("ready and load ready high together");

   // ready only while the sequencer sits idle
   a_ready_idle : assert property (@(posedge clk_i) disable iff (!rstn_i)
      ready_i |-> (state_i == ST_IDLE)) else $error("ready high outside the idle state");

endmodule

bind sublane_driver sublane_assertions #(.VLANE_NUM(VLANE_NUM)) u_assertions (
   .clk_i(clk_i), .rstn_i(rstn_i), .state_i(state), .bwen_i(vrf_bwen_o),
   .store_valid_i(store_data_valid_o), .ready_i(ready_o), .ready_for_load_i(ready_for_load_o)
);

`default_nettype wire

//--- tb_sublane_driver.sv
`default_nettype none

module tb_sublane_driver;
   timeunit 1ns;
   timeprecision 1ps;

   import sublane_pkg::*;

   localparam int VLANE_NUM       = 8;
   localparam int MEM_DEPTH       = 512;
   localparam int MAX_VL_PER_LANE = 256;
   localparam int NROWS           = 9;

   typedef struct packed {
      inst_kind_t  kind;
      logic [11:0] vl;
      elem_width_t width;
      logic [7:0]  delay;
      logic [8:0]  wbase;
      logic [8:0]  rbase0;
      logic [8:0]  rbase1;
      logic [3:0]  beats;   // loads only
      logic [31:0] bwen;    // first load beat, all lanes
   } row_t;

   localparam row_t ROWS [NROWS] = '{
      '{INST_NORMAL, 12'd64, EW_BYTE, 8'd3, 9'h010, 9'h020, 9'h030, 4'd0, 32'h0},
      '{INST_NORMAL, 12'd21, EW_HALF, 8'd2, 9'h040, 9'h050, 9'h060, 4'd0, 32'h0},
      '{INST_NORMAL, 12'd37, EW_WORD, 8'd1, 9'h1fe, 9'h100, 9'h1ff, 4'd0, 32'h0},
      '{INST_NORMAL, 12'd13, EW_BYTE, 8'd6, 9'h070, 9'h080, 9'h090, 4'd0, 32'h0},
      '{INST_STORE,  12'd40, EW_HALF, 8'd1, 9'h0a0, 9'h0b0, 9'h0c0, 4'd0, 32'h0},
      '{INST_LOAD,   12'd16, EW_BYTE, 8'd1, 9'h0d0, 9'h000, 9'h000, 4'd5, 32'h8421f0a5},
      '{INST_STORE,  12'd3,  EW_BYTE, 8'd2, 9'h0e0, 9'h0f0, 9'h1f0, 4'd0, 32'h0},
      '{INST_LOAD,   12'd8,  EW_WORD, 8'd1, 9'h1ff, 9'h000, 9'h000, 4'd1, 32'h0000000f},
      '{INST_NORMAL, 12'd50, EW_HALF, 8'd4, 9'h120, 9'h130, 9'h140, 4'd0, 32'h0}
   };

   logic                      clk_i, rstn_i, start_i;
   inst_kind_t                inst_kind_i;
   logic [11:0]               vl_i;
   elem_width_t               vsew_i;
   logic [7:0]                inst_delay_i;
   logic [8:0]                waddr_base_i;
   logic [1:0][8:0]           raddr_base_i;
   logic                      load_valid_i, load_last_i;
   logic [VLANE_NUM-1:0][3:0] load_bwen_i;
   logic                      ready_o, store_data_valid_o, ready_for_load_o;
   logic [8:0]                vrf_waddr_o;
   logic [1:0][8:0]           vrf_raddr_o;
   logic [VLANE_NUM-1:0][3:0] vrf_bwen_o;
   logic [VLANE_NUM-1:0]      read_data_valid_o;

   int     cycle_cnt = 0;
   int     limit = 0;
   int     errors = 0;
   integer seed = 32'ha650ac0d;

   sublane_driver #(.VLANE_NUM(VLANE_NUM), .MEM_DEPTH(MEM_DEPTH),
                    .MAX_VL_PER_LANE(MAX_VL_PER_LANE)) UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   ////////////////////
   // reference rules
   function automatic int elems_per_word(elem_width_t w);
      case (w)
         EW_BYTE: return 4;
         EW_HALF: return 2;
         default: return 1;
      endcase
   endfunction

   function automatic logic [3:0] bwen_pattern(elem_width_t w, int j);
      case (w)
         EW_BYTE: return 4'b0001 << (j % 4);   // one byte per element
         EW_HALF: return (j % 2 == 0) ? 4'b0011 : 4'b1100;
         default: return 4'b1111;
      endcase
   endfunction

   task automatic fail_run(input string msg);
      errors++;
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         fail_run($sformatf("Error %s: got %h, expected %h", name, got, exp));
      end
   endtask

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > limit) begin
         fail_run($sformatf("timeout, DUT still busy after %0d cycles", limit));
      end
   end

   ////////////////////
   // one instruction per table row
   task automatic run_row(input row_t row);
      int r, d, k, j, offset, beat, last_off, end_off;
      logic gap_q, rfl_exp;
      logic [8:0] exp_addr;
      logic [VLANE_NUM-1:0] exp_valid;
      logic [VLANE_NUM-1:0][3:0] exp_bwen;
      r = (int'(row.vl) + VLANE_NUM - 1) / VLANE_NUM;
      d = int'(row.delay);
      offset = 0;
      beat = 0;
      last_off = 0;
      gap_q = 1'b0;
      @(posedge clk_i);
      #10;
      start_i      = 1'b1;
      inst_kind_i  = row.kind;
      vl_i         = row.vl;
      vsew_i       = row.width;
      inst_delay_i = row.delay;
      waddr_base_i = row.wbase;
      raddr_base_i = {row.rbase1, row.rbase0};
      @(posedge clk_i);   // accepted here
      #10;
      // second start while busy, junk settings
      inst_kind_i  = INST_LOAD;
      vl_i         = '1;
      inst_delay_i = 8'hff;
      waddr_base_i = ~row.wbase;
      raddr_base_i = {~row.rbase1, ~row.rbase0};
      forever begin
         @(negedge clk_i);
         offset++;
         k = offset - 2;   // read element on show
         if (row.kind != INST_LOAD) begin
            exp_valid = '0;
            if (k >= 0 && k < r) begin
               for (int i = 0; i < VLANE_NUM; i++) begin
                  exp_valid[i] = (k * VLANE_NUM + i < int'(row.vl));
               end
               j = (row.kind == INST_STORE) ? k : k / elems_per_word(row.width);
               exp_addr = 9'(int'(row.rbase0) + j);
               expect_equal("vrf_raddr_o[0]", vrf_raddr_o[0], exp_addr);
               exp_addr = 9'(int'(row.rbase1) + j);
               expect_equal("vrf_raddr_o[1]", vrf_raddr_o[1], exp_addr);
            end
            expect_equal("read_data_valid_o", read_data_valid_o, exp_valid);
            expect_equal("store_data_valid_o", store_data_valid_o,
                         (row.kind == INST_STORE) && k >= 0 && k < r);
            j = k - d;   // write element on show
            exp_bwen = '0;
            if (row.kind == INST_NORMAL && j >= 0 && j < r) begin
               for (int i = 0; i < VLANE_NUM; i++) begin
                  exp_bwen[i] = bwen_pattern(row.width, j);
               end
               exp_addr = 9'(int'(row.wbase) + j / elems_per_word(row.width));
               expect_equal("vrf_waddr_o", vrf_waddr_o, exp_addr);
            end
            expect_equal("vrf_bwen_o", vrf_bwen_o, exp_bwen);
            end_off = (row.kind == INST_STORE) ? r + 2 : r + d + 2;
            expect_equal("ready_o", ready_o, offset >= end_off);
            expect_equal("ready_for_load_o", ready_for_load_o, 0);
         end else begin
            rfl_exp = (offset >= 2) && (last_off == 0);
            expect_equal("read_data_valid_o", read_data_valid_o, 0);
            expect_equal("store_data_valid_o", store_data_valid_o, 0);
            expect_equal("ready_for_load_o", ready_for_load_o, rfl_exp);
            expect_equal("vrf_bwen_o", vrf_bwen_o, rfl_exp ? load_bwen_i : '0);
            if (load_valid_i) begin
               exp_addr = 9'(int'(row.wbase) + beat);
               expect_equal("vrf_waddr_o", vrf_waddr_o, exp_addr);
               beat++;
               if (load_last_i) last_off = offset;
            end
            expect_equal("ready_o", ready_o, last_off != 0 && offset > last_off);
         end
         if (ready_o) break;
         @(posedge clk_i);
         #10;
         start_i      = 1'b0;
         load_valid_i = 1'b0;
         load_last_i  = 1'b0;
         load_bwen_i  = '0;
         if (row.kind == INST_LOAD && offset >= 2 && beat < int'(row.beats)) begin
            if (!gap_q && ($random(seed) & 3) == 0) begin
               gap_q = 1'b1;   // at most one idle cycle per beat
            end else begin
               gap_q        = 1'b0;
               load_valid_i = 1'b1;
               load_last_i  = (beat == int'(row.beats) - 1);
               load_bwen_i  = row.bwen ^ {8{4'(beat)}};
            end
         end
      end
      if (row.kind == INST_LOAD) begin
         assert (beat == int'(row.beats)) else begin
            fail_run($sformatf("load finished after %0d of %0d beats", beat, row.beats));
         end
      end
   endtask

   initial begin
      int r;
      rstn_i       = 1'b0;
      start_i      = 1'b0;
      inst_kind_i  = INST_NORMAL;
      vl_i         = '0;
      vsew_i       = EW_BYTE;
      inst_delay_i = '0;
      waddr_base_i = '0;
      raddr_base_i = '0;
      load_valid_i = 1'b0;
      load_last_i  = 1'b0;
      load_bwen_i  = '0;
      limit = 10;   // reset and settle
      for (int n = 0; n < NROWS; n++) begin
         r = (int'(ROWS[n].vl) + VLANE_NUM - 1) / VLANE_NUM;
         limit += r + int'(ROWS[n].delay) + 2 * int'(ROWS[n].beats) + 10;
      end
      repeat (5) @(posedge clk_i);
      #10;
      rstn_i = 1'b1;
      @(negedge clk_i);
      expect_equal("ready_o", ready_o, 1);
      expect_equal("read_data_valid_o", read_data_valid_o, 0);
      expect_equal("vrf_bwen_o", vrf_bwen_o, 0);
      expect_equal("store_data_valid_o", store_data_valid_o, 0);
      expect_equal("ready_for_load_o", ready_for_load_o, 0);
      expect_equal("vrf_waddr_o", vrf_waddr_o, 0);
      expect_equal("vrf_raddr_o", vrf_raddr_o, 0);
      for (int n = 0; n < NROWS; n++) begin
         run_row(ROWS[n]);
      end
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
sublane_pkg.sv
sublane_cfg_regs.sv
sublane_fsm.sv
vrf_addr_counter.sv
byte_enable_gen.sv
sublane_driver.sv
sublane_assertions.sv
tb_sublane_driver.sv

//--- Makefile
TOP = tb_sublane_driver

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f build.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
